// File: build.sh
#!/bin/sh
# Builds the datapath with its testbench in Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module datapathTb \
    -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdatapathTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: common/datapathPkg.sv
`default_nettype none

package datapathPkg;

    // **********************************************************************
    // Widths
    // **********************************************************************
    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regSelWidth = 4;
    localparam int opWidth     = 5;

    // **********************************************************************
    // ALU opcodes
    // **********************************************************************
    localparam logic [opWidth-1:0] opAdd = 5'b00011;
    localparam logic [opWidth-1:0] opSub = 5'b00100;
    localparam logic [opWidth-1:0] opShr = 5'b00101;
    localparam logic [opWidth-1:0] opShl = 5'b00110;
    localparam logic [opWidth-1:0] opOr  = 5'b01010;
    localparam logic [opWidth-1:0] opAnd = 5'b01011;
    localparam logic [opWidth-1:0] opMul = 5'b01111;
    localparam logic [opWidth-1:0] opDiv = 5'b10000;
    localparam logic [opWidth-1:0] opNeg = 5'b10001;
    localparam logic [opWidth-1:0] opNot = 5'b10010;

    // The same IR word seen as a three-register or as a register-constant format.
    typedef union packed {
        struct packed {
            logic [opWidth-1:0]     opcode;
            logic [regSelWidth-1:0] ra;
            logic [regSelWidth-1:0] rb;
            logic [regSelWidth-1:0] rc;
            logic [14:0]            unused;
        } rFmt;
        struct packed {
            logic [opWidth-1:0]     opcode;
            logic [regSelWidth-1:0] ra;
            logic [regSelWidth-1:0] rb;
            logic [18:0]            c;        // Signed constant field.
        } iFmt;
    } instrWord;

endpackage

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [datapathPkg::dataWidth-1:0]   yValue,
    input  logic [datapathPkg::dataWidth-1:0]   busValue,
    input  logic [datapathPkg::opWidth-1:0]     opcode,
    input  logic                                incPc,
    output logic [2*datapathPkg::dataWidth-1:0] aluResult
);
    import datapathPkg::*;

    logic signed [dataWidth-1:0]   aSigned;
    logic signed [dataWidth-1:0]   bSigned;
    logic signed [2*dataWidth-1:0] product;
    logic signed [dataWidth-1:0]   quotient;
    logic signed [dataWidth-1:0]   remainder;
    logic                          divByZero;

    assign aSigned   = yValue;      // Y is operand A.
    assign bSigned   = busValue;    // The bus is operand B.
    assign divByZero = (busValue == '0);

    // **********************************************************************
    // Multiply and divide
    // **********************************************************************
    assign product = 64'(aSigned) * 64'(bSigned);

    always_comb begin
        if (divByZero) begin
            quotient  = '1;
            remainder = aSigned;
        end else begin
            quotient  = aSigned / bSigned;
            remainder = aSigned % bSigned;
        end
    end

    // **********************************************************************
    // Result select
    // **********************************************************************
    always_comb begin
        aluResult = '0;
        if (incPc) begin
            // The PC increment overrides whatever opcode is on the lines.
            aluResult[dataWidth-1:0] = busValue + 1'b1;
        end else begin
            case (opcode)
                opAdd: aluResult[dataWidth-1:0] = yValue + busValue;
                opSub: aluResult[dataWidth-1:0] = yValue - busValue;
                opShr: aluResult[dataWidth-1:0] = yValue >> busValue[4:0];
                opShl: aluResult[dataWidth-1:0] = yValue << busValue[4:0];
                opOr:  aluResult[dataWidth-1:0] = yValue | busValue;
                opAnd: aluResult[dataWidth-1:0] = yValue & busValue;
                opNeg: aluResult[dataWidth-1:0] = -busValue;
                opNot: aluResult[dataWidth-1:0] = ~busValue;
                opMul: aluResult = product;
                opDiv: aluResult = {remainder, quotient}; // Remainder high, quotient low.
                default: aluResult = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: datapath/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
    input  logic                                                   Clock,
    input  logic                                                   rstN,
    input  logic [datapathPkg::regCount-1:0]                       regOut,
    input  logic [datapathPkg::regCount-1:0][datapathPkg::dataWidth-1:0] regData,
    input  logic                                                   pcOut,
    input  logic [datapathPkg::dataWidth-1:0]                      pcValue,
    input  logic                                                   mdrOut,
    input  logic [datapathPkg::dataWidth-1:0]                      mdrValue,
    input  logic                                                   zHighOut,
    input  logic [datapathPkg::dataWidth-1:0]                      zHighValue,
    input  logic                                                   zLowOut,
    input  logic [datapathPkg::dataWidth-1:0]                      zLowValue,
    input  logic                                                   hiOut,
    input  logic [datapathPkg::dataWidth-1:0]                      hiValue,
    input  logic                                                   loOut,
    input  logic [datapathPkg::dataWidth-1:0]                      loValue,
    input  logic                                                   cOut,
    input  logic [datapathPkg::dataWidth-1:0]                      constValue,
    output logic [datapathPkg::dataWidth-1:0]                      busValue
);
    import datapathPkg::*;

    logic [regCount+6:0] outStrobes;

    assign outStrobes = {regOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut};

    // Each source is masked by its strobe and all are ORed, so an idle bus reads zero.
    always_comb begin
        busValue = '0;
        for (int i = 0; i < regCount; i++) begin
            busValue |= {dataWidth{regOut[i]}} & regData[i];
        end
        busValue |= {dataWidth{pcOut}}    & pcValue;
        busValue |= {dataWidth{mdrOut}}   & mdrValue;
        busValue |= {dataWidth{zHighOut}} & zHighValue;
        busValue |= {dataWidth{zLowOut}}  & zLowValue;
        busValue |= {dataWidth{hiOut}}    & hiValue;
        busValue |= {dataWidth{loOut}}    & loValue;
        busValue |= {dataWidth{cOut}}     & constValue;
    end

    // **********************************************************************
    // A second driver would silently merge two words on the bus.
    // **********************************************************************
    singleDriver: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0(outStrobes))
        else $error("busMux: more than one out-strobe high, strobes=%b", outStrobes);

endmodule

`default_nettype wire

// File: datapath/controlRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module controlRegisters (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [datapathPkg::dataWidth-1:0]   busValue,
    input  logic [datapathPkg::dataWidth-1:0]   mDataIn,
    input  logic                                read,
    input  logic [2*datapathPkg::dataWidth-1:0] aluResult,
    input  logic                                pcIn,
    input  logic                                irIn,
    input  logic                                yIn,
    input  logic                                zIn,
    input  logic                                hiIn,
    input  logic                                loIn,
    input  logic                                marIn,
    input  logic                                mdrIn,
    output logic [datapathPkg::dataWidth-1:0]   pcValue,
    output logic [datapathPkg::dataWidth-1:0]   mdrValue,
    output logic [datapathPkg::dataWidth-1:0]   yValue,
    output logic [datapathPkg::dataWidth-1:0]   zHighValue,
    output logic [datapathPkg::dataWidth-1:0]   zLowValue,
    output logic [datapathPkg::dataWidth-1:0]   hiValue,
    output logic [datapathPkg::dataWidth-1:0]   loValue,
    output logic [datapathPkg::dataWidth-1:0]   marValue,
    output logic [datapathPkg::dataWidth-1:0]   constValue
);
    import datapathPkg::*;

    instrWord             irValue;
    logic [dataWidth-1:0] mdrSource;

    assign mdrSource = read ? mDataIn : busValue; // Memory wins while a read is active.

    // **********************************************************************
    // Special registers, all loaded on the rising edge under their strobe
    // **********************************************************************
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcValue    <= '0;
            irValue    <= '0;
            yValue     <= '0;
            zHighValue <= '0;
            zLowValue  <= '0;
            hiValue    <= '0;
            loValue    <= '0;
            marValue   <= '0;
            mdrValue   <= '0;
        end else begin
            if (pcIn)  pcValue  <= busValue;
            if (irIn)  irValue  <= busValue;
            if (yIn)   yValue   <= busValue;
            if (hiIn)  hiValue  <= busValue;
            if (loIn)  loValue  <= busValue;
            if (marIn) marValue <= busValue;
            if (mdrIn) mdrValue <= mdrSource;
            if (zIn) begin
                {zHighValue, zLowValue} <= aluResult;
            end
        end
    end

    // The 19-bit constant of the immediate format, sign-extended for the bus.
    assign constValue = {{(dataWidth - 19){irValue.iFmt.c[18]}}, irValue.iFmt.c};

    // A memory word has nowhere to land unless MDR is being loaded.
    readLoadsMdr: assert property (@(posedge Clock) disable iff (!rstN)
        read |-> mdrIn)
        else $error("controlRegisters: read high without mdrIn");

endmodule

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                               Clock,
    input  logic                               rstN,
    input  logic [datapathPkg::dataWidth-1:0]  mDataIn,
    input  logic                               read,
    input  logic                               incPc,
    input  logic [datapathPkg::regCount-1:0]   regIn,
    input  logic [datapathPkg::regCount-1:0]   regOut,
    input  logic                               pcIn,
    input  logic                               irIn,
    input  logic                               yIn,
    input  logic                               zIn,
    input  logic                               hiIn,
    input  logic                               loIn,
    input  logic                               marIn,
    input  logic                               mdrIn,
    input  logic                               pcOut,
    input  logic                               mdrOut,
    input  logic                               zHighOut,
    input  logic                               zLowOut,
    input  logic                               hiOut,
    input  logic                               loOut,
    input  logic                               cOut,
    input  logic [datapathPkg::opWidth-1:0]    opcode,
    output logic [datapathPkg::dataWidth-1:0]  busValue,
    output logic [datapathPkg::dataWidth-1:0]  marValue
);
    import datapathPkg::*;

    logic [regCount-1:0][dataWidth-1:0] regData;
    logic [dataWidth-1:0]   pcValue, mdrValue, yValue;
    logic [dataWidth-1:0]   zHighValue, zLowValue, hiValue, loValue, constValue;
    logic [2*dataWidth-1:0] aluResult;

    busMux uBusMux (
        .Clock(Clock), .rstN(rstN),
        .regOut(regOut), .regData(regData),
        .pcOut(pcOut), .pcValue(pcValue),
        .mdrOut(mdrOut), .mdrValue(mdrValue),
        .zHighOut(zHighOut), .zHighValue(zHighValue),
        .zLowOut(zLowOut), .zLowValue(zLowValue),
        .hiOut(hiOut), .hiValue(hiValue),
        .loOut(loOut), .loValue(loValue),
        .cOut(cOut), .constValue(constValue),
        .busValue(busValue)
    );

    registerFile uRegisterFile (
        .Clock(Clock), .rstN(rstN), .regIn(regIn), .busValue(busValue), .regData(regData)
    );

    alu uAlu (
        .yValue(yValue), .busValue(busValue), .opcode(opcode), .incPc(incPc),
        .aluResult(aluResult)
    );

    controlRegisters uControlRegisters (
        .Clock(Clock), .rstN(rstN), .busValue(busValue), .mDataIn(mDataIn),
        .read(read), .aluResult(aluResult),
        .pcIn(pcIn), .irIn(irIn), .yIn(yIn), .zIn(zIn),
        .hiIn(hiIn), .loIn(loIn), .marIn(marIn), .mdrIn(mdrIn),
        .pcValue(pcValue), .mdrValue(mdrValue), .yValue(yValue),
        .zHighValue(zHighValue), .zLowValue(zLowValue),
        .hiValue(hiValue), .loValue(loValue), .marValue(marValue),
        .constValue(constValue)
    );

endmodule

`default_nettype wire

// File: datapath/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                                                   Clock,
    input  logic                                                   rstN,
    input  logic [datapathPkg::regCount-1:0]                       regIn,
    input  logic [datapathPkg::dataWidth-1:0]                      busValue,
    output logic [datapathPkg::regCount-1:0][datapathPkg::dataWidth-1:0] regData
);
    import datapathPkg::*;

    // The general registers R0 to R15.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            regData <= '0;
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (regIn[i]) begin
                    regData[i] <= busValue; // Only the strobed register changes.
                end
            end
        end
    end

    // The control unit names one destination per transfer.
    oneDestination: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0(regIn))
        else $error("registerFile: regIn not one-hot, regIn=%h", regIn);

endmodule

`default_nettype wire

// File: src.f
common/datapathPkg.sv
datapath/busMux.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/controlRegisters.sv
datapath/datapath.sv
verification/clockGen.sv
verification/datapathTb.sv

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic Clock,
    output logic rstN
);
    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock; // 4 ns period.
    end

    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge Clock);
        #1 rstN = 1'b1;            // Released clear of the edge.
    end

endmodule

`default_nettype wire

// File: verification/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;
    import datapathPkg::*;

    localparam int stepCount = 160;                     // Transfers over all six tests, rounded up.
    localparam int timeoutNs = (stepCount + 8) * 4 * 2;

    logic Clock, rstN, read, incPc, pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn;
    logic pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut, checkBus;
    logic [regCount-1:0]    regIn, regOut;
    logic [opWidth-1:0]     opcode;
    logic [dataWidth-1:0]   mDataIn, busValue, marValue, expectedBus;
    logic [dataWidth-1:0]   a, b, oldPc, constExpected;
    logic [dataWidth-1:0]   regModel [regCount];
    logic [opWidth-1:0]     opList [10];
    logic [2*dataWidth-1:0] product;
    instrWord               irWord;
    int seed = 49;
    int errorCount = 0;
    int testErrors = 0;
    int testCount = 0;
    int failedTests = 0;

    clockGen uClockGen (.Clock(Clock), .rstN(rstN));

    datapath DUT (.*);

    // Bus values are sampled on the edge that completes each transfer.
    busMatches: assert property (@(posedge Clock) disable iff (!rstN)
        checkBus |-> busValue == expectedBus)
        else begin
            $display("[FAIL] busValue = %h, expected %h", $sampled(busValue),
                     $sampled(expectedBus));
            errorCount = errorCount + 1;
        end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired at %0d ns before the tests completed", $time);
        $display("Test failures found");
        $finish;
    end

    // **********************************************************************
    // Step helpers
    // **********************************************************************
    task automatic clearStrobes();
        {read, incPc, pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn} = '0;
        {pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut} = '0;
        regIn    = '0;
        regOut   = '0;
        opcode   = '0;
        checkBus = 1'b0;
    endtask

    task automatic nextCycle();
        @(posedge Clock);
        #1;
        clearStrobes();
    endtask

    task automatic expectBus(input logic [dataWidth-1:0] value);
        checkBus    = 1'b1;
        expectedBus = value;
    endtask

    task automatic loadRegister(input int idx, input logic [dataWidth-1:0] value);
        mDataIn = value;
        read    = 1'b1;
        mdrIn   = 1'b1;
        nextCycle();
        mdrOut      = 1'b1;
        regIn[idx]  = 1'b1;
        expectBus(value);
        nextCycle();
        regModel[idx] = value;
    endtask

    task automatic checkMar(input logic [dataWidth-1:0] value);
        assert (marValue === value) else begin
            $display("[FAIL] marValue = %h, expected %h", marValue, value);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testErrors) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // ALU rules with Y as A and the bus as B.
    function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] ia,
                                             input logic [31:0] ib);
        logic signed [63:0] wideA;
        logic signed [63:0] wideB;
        wideA = {{32{ia[31]}}, ia};
        wideB = {{32{ib[31]}}, ib};
        case (op)
            opAdd: return {32'h0, ia + ib};
            opSub: return {32'h0, ia - ib};
            opShr: return {32'h0, ia >> ib[4:0]};
            opShl: return {32'h0, ia << ib[4:0]};
            opOr:  return {32'h0, ia | ib};
            opAnd: return {32'h0, ia & ib};
            opNeg: return {32'h0, ~ib + 32'h1};
            opNot: return {32'h0, ~ib};
            opMul: return wideA * wideB;
            opDiv: return (ib == 0) ? {ia, 32'hFFFF_FFFF}
                                    : {32'(wideA % wideB), 32'(wideA / wideB)};
            default: return 64'h0;
        endcase
    endfunction

    // The reference T3 to T5 sequence with both halves of Z read back.
    task automatic runAluOp(input logic [4:0] op, input logic [31:0] ia, input logic [31:0] ib);
        logic [63:0] expected;
        expected = aluModel(op, ia, ib);
        loadRegister(4, ib);
        loadRegister(6, ia);
        regOut[6] = 1'b1;
        yIn       = 1'b1;
        expectBus(ia);
        nextCycle();
        regOut[4] = 1'b1;
        opcode    = op;
        zIn       = 1'b1;
        expectBus(ib);
        nextCycle();
        zLowOut = 1'b1;
        expectBus(expected[31:0]);
        nextCycle();
        zHighOut = 1'b1;
        expectBus(expected[63:32]);
        nextCycle();
    endtask

    // **********************************************************************
    // Tests
    // **********************************************************************
    initial begin
        clearStrobes();
        mDataIn = '0;
        opList  = '{opAdd, opSub, opShr, opShl, opOr, opAnd, opMul, opDiv, opNeg, opNot};
        for (int i = 0; i < regCount; i++) regModel[i] = '0;
        wait (rstN === 1'b1);
        @(posedge Clock);
        #1;

        checkMar('0);
        for (int i = 0; i < regCount + 7; i++) begin
            if (i < regCount) begin
                regOut[i] = 1'b1;
            end else begin
                {pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut} =
                    7'b1000000 >> (i - regCount);
            end
            expectBus('0);
            nextCycle();
        end
        finishTest("reset state");

        loadRegister(4, $random(seed));
        loadRegister(6, $random(seed));
        for (int i = 0; i < regCount; i++) begin
            regOut[i] = 1'b1;
            expectBus(regModel[i]);
            nextCycle();
        end
        finishTest("load through MDR");

        oldPc = $random(seed);
        loadRegister(7, oldPc);
        regOut[7] = 1'b1;
        pcIn      = 1'b1;
        expectBus(oldPc);
        nextCycle();
        {pcOut, marIn, incPc, zIn} = 4'b1111;
        expectBus(oldPc);
        nextCycle();
        checkMar(oldPc);
        zLowOut = 1'b1;
        expectBus(oldPc + 32'h1);
        nextCycle();
        finishTest("PC increment");

        for (int i = 0; i < 10; i++) begin
            a = $random(seed);
            b = $random(seed);
            runAluOp(opList[i], a, b);
        end
        runAluOp(opDiv, $random(seed), '0);  // Division by zero.
        finishTest("ALU opcodes");

        irWord.iFmt.opcode = opAdd;
        irWord.iFmt.ra     = 4'd1;
        irWord.iFmt.rb     = 4'd2;
        irWord.iFmt.c      = 19'($random(seed)) | 19'h40000;
        constExpected      = 32'($signed(irWord.iFmt.c));
        loadRegister(8, irWord);
        regOut[8] = 1'b1;
        irIn      = 1'b1;
        expectBus(irWord);
        nextCycle();
        cOut = 1'b1;
        expectBus(constExpected);
        nextCycle();
        finishTest("IR constant");

        a = $random(seed);
        b = $random(seed);
        product = aluModel(opMul, a, b);
        runAluOp(opMul, a, b);
        zHighOut = 1'b1;
        hiIn     = 1'b1;
        expectBus(product[63:32]);
        nextCycle();
        zLowOut = 1'b1;
        loIn    = 1'b1;
        expectBus(product[31:0]);
        nextCycle();
        hiOut = 1'b1;
        expectBus(product[63:32]);
        nextCycle();
        loOut = 1'b1;
        expectBus(product[31:0]);
        nextCycle();
        finishTest("HI and LO");

        $display("%0d tests, %0d passed, %0d failed, %0d errors", testCount,
                 testCount - failedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
